// File: verilog.f
+incdir+hw
hw/mem_pkg.sv
hw/ddr_if.sv
hw/channel_arb.sv
hw/ddr_array.sv
hw/burst_collector.sv
hw/mem_subsys_top.sv
verification/mem_subsys_sva.sv
verification/mem_subsys_tb.sv

// File: verification/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsys_tb;

    typedef struct {
        logic [2:0]             chans;     // Bit 0 sw, bit 1 lw, bit 2 pc
        logic [`MEM_ADDR_W-1:0] sw_idx;
        logic [`MEM_ADDR_W-1:0] lw_idx;    // First index of a load stream
        int                     lw_cnt;    // Loads at consecutive indices
        logic [`MEM_ADDR_W-1:0] pc_idx;
        logic [`MEM_DATA_W-1:0] mask;
        logic [`MEM_DATA_W-1:0] data;
    } stim_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [`MEM_ADDR_W-1:0] pc_index;
    logic                   pc_index_valid;
    logic [`LINE_W-1:0]     arb2pc_fetch_burst_read_inst;
    logic                   pc_index_ready;
    logic [`MEM_ADDR_W-1:0] sw_index;
    logic                   sw_index_valid;
    logic [`MEM_DATA_W-1:0] sw2arb_write_mask;
    logic [`MEM_DATA_W-1:0] sw2ddr_write_data;
    logic                   sw_index_ready;
    logic [`MEM_ADDR_W-1:0] lw_index;
    logic                   lw_index_valid;
    logic [`MEM_DATA_W-1:0] arb2lw_read_data;
    logic                   lw_index_ready;

    stim_t                  tbl [64];                          // Stimulus table
    int                     n_entries;
    logic                   table_ready = 1'b0;                // Starts the watchdog
    logic [`MEM_DATA_W-1:0] ref_mem [1 << `MEM_DEPTH_LOG2];    // Expected memory contents
    int                     word_errs;
    int                     line_errs;
    int                     flag_errs;
    int                     order_errs;

    always #2 clk = ~clk;    // 4 ns period

    mem_subsys_top UUT (
        .clk                          (clk),
        .rst_n                        (rst_n),
        .pc_index                     (pc_index),
        .pc_index_valid               (pc_index_valid),
        .arb2pc_fetch_burst_read_inst (arb2pc_fetch_burst_read_inst),
        .pc_index_ready               (pc_index_ready),
        .sw_index                     (sw_index),
        .sw_index_valid               (sw_index_valid),
        .sw2arb_write_mask            (sw2arb_write_mask),
        .sw2ddr_write_data            (sw2ddr_write_data),
        .sw_index_ready               (sw_index_ready),
        .lw_index                     (lw_index),
        .lw_index_valid               (lw_index_valid),
        .arb2lw_read_data             (arb2lw_read_data),
        .lw_index_ready               (lw_index_ready)
    );

    task automatic check_word(input string name, input logic [`MEM_DATA_W-1:0] exp,
                              input logic [`MEM_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            word_errs++;
        end
    endtask

    task automatic check_line(input string name, input logic [`LINE_W-1:0] exp,
                              input logic [`LINE_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            line_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            flag_errs++;
        end
    endtask

    task automatic report_order(input string what);
        $display("Order error at %0t: %s", $time, what);
        order_errs++;
    endtask

    function automatic logic [`MEM_DATA_W-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // Store into the reference memory bit by bit
    task automatic apply_store(input logic [`MEM_DEPTH_LOG2-1:0] a,
                               input logic [`MEM_DATA_W-1:0] mask,
                               input logic [`MEM_DATA_W-1:0] data);
        int b;
        for (b = 0; b < `MEM_DATA_W; b++) begin
            if (mask[b]) begin
                ref_mem[a][b] = data[b];    // Unmasked bits keep the old value
            end
        end
    endtask

    // Aligned line from the reference memory with word k in slot k
    function automatic logic [`LINE_W-1:0] expect_line(input logic [`MEM_ADDR_W-1:0] idx);
        logic [`LINE_W-1:0]     l;
        logic [`MEM_ADDR_W-1:0] base;
        int                     k;
        base = idx & ~`MEM_ADDR_W'(`BURST_BEATS - 1);
        for (k = 0; k < `BURST_BEATS; k++) begin
            l[k*`MEM_DATA_W +: `MEM_DATA_W] = ref_mem[`MEM_DEPTH_LOG2'(base + k)];
        end
        return l;
    endfunction

    task automatic add_entry(input logic [2:0] chans, input logic [`MEM_ADDR_W-1:0] sw_idx,
                             input logic [`MEM_ADDR_W-1:0] lw_idx, input int lw_cnt,
                             input logic [`MEM_ADDR_W-1:0] pc_idx,
                             input logic [`MEM_DATA_W-1:0] mask,
                             input logic [`MEM_DATA_W-1:0] data);
        tbl[n_entries].chans  = chans;
        tbl[n_entries].sw_idx = sw_idx;
        tbl[n_entries].lw_idx = lw_idx;
        tbl[n_entries].lw_cnt = lw_cnt;
        tbl[n_entries].pc_idx = pc_idx;
        tbl[n_entries].mask   = mask;
        tbl[n_entries].data   = data;
        n_entries++;
    endtask

    task automatic build_table();
        int                     i;
        logic [`MEM_ADDR_W-1:0] idx;
        for (i = 0; i < 6; i++) begin                                  // Masked merge words
            idx = `MEM_ADDR_W'(19'h040 + i * 37);
            add_entry(3'b001, idx, '0, 0, '0, '1, rand64());          // Known base word
            add_entry(3'b001, idx, '0, 0, '0, rand64(), rand64());    // Random mask
            add_entry(3'b010, '0, (i == 5) ? (idx | 19'h70000) : idx, 1, '0, '0, '0);
        end
        for (i = 0; i < 16; i++) begin                                 // Fill lines 0x100 and 0x108
            add_entry(3'b001, `MEM_ADDR_W'(19'h100 + i), '0, 0, '0, '1, rand64());
        end
        add_entry(3'b100, '0, '0, 0, 19'h105, '0, '0);                // Fetch with beat 5 in index
        add_entry(3'b001, 19'h200, '0, 0, '0, '1, rand64());
        add_entry(3'b111, 19'h200, 19'h200, 1, 19'h10e, rand64(), rand64());  // All three at once
        add_entry(3'b110, '0, 19'h100, 5, 19'h10b, '0, '0);           // Fetch behind a load stream
    endtask

    // Outputs stay quiet after reset until a request is made
    task automatic check_idle();
        repeat (3) begin
            @(negedge clk);
            check_flag("sw_index_ready", 1'b0, sw_index_ready);
            check_flag("lw_index_ready", 1'b0, lw_index_ready);
            check_flag("pc_index_ready", 1'b0, pc_index_ready);
            check_word("arb2lw_read_data", '0, arb2lw_read_data);
            check_line("arb2pc_fetch_burst_read_inst", '0, arb2pc_fetch_burst_read_inst);
        end
    endtask

    task automatic run_entry(input int e);
        logic                       sw_pend;
        logic                       lw_pend;
        logic                       pc_pend;
        int                         lw_left;
        logic [`MEM_ADDR_W-1:0]     lw_cur;
        sw_pend = tbl[e].chans[0];
        lw_pend = tbl[e].chans[1];
        pc_pend = tbl[e].chans[2];
        lw_left = tbl[e].lw_cnt;
        lw_cur  = tbl[e].lw_idx;
        @(posedge clk);
        sw_index          <= tbl[e].sw_idx;
        sw2arb_write_mask <= tbl[e].mask;
        sw2ddr_write_data <= tbl[e].data;
        lw_index          <= lw_cur;
        pc_index          <= tbl[e].pc_idx;
        sw_index_valid    <= sw_pend;
        lw_index_valid    <= lw_pend;
        pc_index_valid    <= pc_pend;
        while (sw_pend || lw_pend || pc_pend) begin
            @(negedge clk);                                      // Outputs settled mid-cycle
            if (!sw_pend) check_flag("sw_index_ready", 1'b0, sw_index_ready);
            if (!lw_pend) check_flag("lw_index_ready", 1'b0, lw_index_ready);
            if (!pc_pend) check_flag("pc_index_ready", 1'b0, pc_index_ready);
            if (sw_index_ready && sw_pend) begin
                apply_store(tbl[e].sw_idx[`MEM_DEPTH_LOG2-1:0], tbl[e].mask, tbl[e].data);
                sw_pend = 1'b0;
            end
            if (lw_index_ready && lw_pend) begin
                if (sw_pend) report_order("load answered before the pending store");
                check_word("arb2lw_read_data", ref_mem[lw_cur[`MEM_DEPTH_LOG2-1:0]],
                           arb2lw_read_data);
                lw_left--;
                lw_pend = (lw_left > 0);
                lw_cur  = lw_cur + 1'b1;                         // Next load of the stream
            end else begin
                check_word("arb2lw_read_data", '0, arb2lw_read_data);
            end
            if (pc_index_ready && pc_pend) begin
                if (sw_pend || lw_pend) begin
                    report_order("fetch answered before a pending store or load");
                end
                check_line("arb2pc_fetch_burst_read_inst", expect_line(tbl[e].pc_idx),
                           arb2pc_fetch_burst_read_inst);
                pc_pend = 1'b0;
            end else begin
                check_line("arb2pc_fetch_burst_read_inst", '0, arb2pc_fetch_burst_read_inst);
            end
            @(posedge clk);                                      // Drop or advance after ready
            sw_index_valid <= sw_pend;
            lw_index_valid <= lw_pend;
            lw_index       <= lw_cur;
            pc_index_valid <= pc_pend;
        end
    endtask

    initial begin
        int e;
        void'($urandom(32'ha161a019));
        rst_n             = 1'b0;
        pc_index          = '0;
        pc_index_valid    = 1'b0;
        sw_index          = '0;
        sw_index_valid    = 1'b0;
        sw2arb_write_mask = '0;
        sw2ddr_write_data = '0;
        lw_index          = '0;
        lw_index_valid    = 1'b0;
        word_errs         = 0;
        line_errs         = 0;
        flag_errs         = 0;
        order_errs        = 0;
        n_entries         = 0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_idle();
        table_ready = 1'b1;
        for (e = 0; e < n_entries; e++) begin
            run_entry(e);
        end
        repeat (4) @(posedge clk);
        $display("Error counts: word %0d, line %0d, flag %0d, order %0d",
                 word_errs, line_errs, flag_errs, order_errs);
        if (word_errs + line_errs + flag_errs + order_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Budget of 12 cycles per table entry plus margin
    initial begin
        wait (table_ready);
        repeat (n_entries * 12 + 50) @(posedge clk);
        $display("Timeout: a channel never got its ready within %0d cycles, the run hung",
                 n_entries * 12 + 50);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/mem_subsys_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_sva (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sw_valid,
    input  logic  lw_valid,
    input  logic  pc_valid,
    input  logic  sw_ready,
    input  logic  lw_ready,
    input  logic  pc_ready,
    input  logic  chip_enable,    // Command strobe on the memory port
    input  logic  ddr_ready       // Memory idle flag
);

    // Command strobe is a single-cycle pulse
    a_ce_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) chip_enable |=> !chip_enable
    ) else $error("chip_enable high on two consecutive cycles");

    // Only one channel completes per cycle
    a_one_ready: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({sw_ready, lw_ready, pc_ready})
    ) else $error("more than one ready high in the same cycle");

    // A ready never answers a channel that is not requesting
    a_sw_ready: assert property (
        @(posedge clk) disable iff (!rst_n) sw_ready |-> sw_valid
    ) else $error("sw_index_ready without sw_index_valid");

    a_lw_ready: assert property (
        @(posedge clk) disable iff (!rst_n) lw_ready |-> lw_valid
    ) else $error("lw_index_ready without lw_index_valid");

    a_pc_ready: assert property (
        @(posedge clk) disable iff (!rst_n) pc_ready |-> pc_valid
    ) else $error("pc_index_ready without pc_index_valid");

    // Commands only go out while the memory is idle
    a_ce_idle: assert property (
        @(posedge clk) disable iff (!rst_n) chip_enable |-> ddr_ready
    ) else $error("chip_enable issued while ddr_ready is low");

endmodule

bind channel_arb mem_subsys_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .sw_valid    (sw_index_valid),
    .lw_valid    (lw_index_valid),
    .pc_valid    (pc_index_valid),
    .sw_ready    (sw_index_ready),
    .lw_ready    (lw_index_ready),
    .pc_ready    (pc_index_ready),
    .chip_enable (ddr.chip_enable),
    .ddr_ready   (ddr.ddr_ready)
);

`default_nettype wire

// File: hw/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsys_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Fetch channel
    input  logic [`MEM_ADDR_W-1:0]  pc_index,
    input  logic                    pc_index_valid,
    output logic [`LINE_W-1:0]      arb2pc_fetch_burst_read_inst,   // Aligned 8-word line
    output logic                    pc_index_ready,

    // Store channel
    input  logic [`MEM_ADDR_W-1:0]  sw_index,
    input  logic                    sw_index_valid,
    input  logic [`MEM_DATA_W-1:0]  sw2arb_write_mask,
    input  logic [`MEM_DATA_W-1:0]  sw2ddr_write_data,
    output logic                    sw_index_ready,

    // Load channel
    input  logic [`MEM_ADDR_W-1:0]  lw_index,
    input  logic                    lw_index_valid,
    output logic [`MEM_DATA_W-1:0]  arb2lw_read_data,
    output logic                    lw_index_ready
);

    logic [`LINE_W-1:0] line;         // Collector to arbiter
    logic               line_valid;

    ddr_if ddr_bus ();                // Internal memory port

    channel_arb u_arb (
        .clk                          (clk),
        .rst_n                        (rst_n),
        .sw_index                     (sw_index),
        .lw_index                     (lw_index),
        .pc_index                     (pc_index),
        .sw_index_valid               (sw_index_valid),
        .lw_index_valid               (lw_index_valid),
        .pc_index_valid               (pc_index_valid),
        .sw2arb_write_mask            (sw2arb_write_mask),
        .sw2ddr_write_data            (sw2ddr_write_data),
        .line                         (line),
        .line_valid                   (line_valid),
        .ddr                          (ddr_bus.ctrl),
        .sw_index_ready               (sw_index_ready),
        .lw_index_ready               (lw_index_ready),
        .pc_index_ready               (pc_index_ready),
        .arb2lw_read_data             (arb2lw_read_data),
        .arb2pc_fetch_burst_read_inst (arb2pc_fetch_burst_read_inst)
    );

    ddr_array u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (ddr_bus.mem)
    );

    burst_collector u_coll (
        .clk        (clk),
        .rst_n      (rst_n),
        .mon        (ddr_bus.mon),
        .line       (line),
        .line_valid (line_valid)
    );

endmodule

`default_nettype wire

// File: hw/burst_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module burst_collector (
    input  logic               clk,
    input  logic               rst_n,
    ddr_if.mon                 mon,
    output logic [`LINE_W-1:0] line,         // Word k in bits 64k+63:64k
    output logic               line_valid    // One cycle after beat 7
);

    logic               armed;       // A burst is returning
    logic [`BEAT_W-1:0] beat_cnt;    // Slot for the next beat
    logic               burst_cmd;   // Line read accepted by the memory
    logic               take;        // Beat to store this cycle

    assign burst_cmd = mon.chip_enable && mon.ddr_ready && mon.burst_mode && !mon.write_enable;
    assign take      = armed && mon.rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed      <= 1'b0;
            beat_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= 1'b0;
            if (burst_cmd) begin
                armed    <= 1'b1;
                beat_cnt <= '0;                        // Beats come in order 0..7
            end else if (take) begin
                beat_cnt <= beat_cnt + `BEAT_W'(1);
                if (beat_cnt == `BEAT_W'(`BURST_BEATS - 1)) begin
                    armed      <= 1'b0;
                    line_valid <= 1'b1;                // Whole line present
                end
            end
        end
    end

    // Each beat lands in its own slot; the line is held until overwritten
    always_ff @(posedge clk) begin
        if (take) begin
            line[beat_cnt*`MEM_DATA_W +: `MEM_DATA_W] <= mon.rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/ddr_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module ddr_array import mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    ddr_if.mem    mem
);

    localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

    logic [`MEM_DATA_W-1:0]     mem_q [DEPTH];   // Storage, contents survive reset
    mem_index_u                 cur_idx;         // Beat being returned in a burst
    mem_index_u                 nxt_idx;         // Following beat of the same line
    logic                       start;           // Command accepted this cycle
    logic                       bursting;        // Beats 1..7 still to send
    logic                       last_beat;
    logic [`MEM_DEPTH_LOG2-1:0] cmd_addr;
    logic [`MEM_DEPTH_LOG2-1:0] nxt_addr;
    logic [`MEM_DATA_W-1:0]     merged;          // Old word with masked bits replaced

    assign start    = mem.chip_enable && mem.ddr_ready;
    assign cmd_addr = mem.ddr_index.word[`MEM_DEPTH_LOG2-1:0];   // Upper bits dropped

    // Step the beat field, the line number stays put
    always_comb begin
        nxt_idx         = cur_idx;
        nxt_idx.ln.beat = cur_idx.ln.beat + `BEAT_W'(1);
    end

    assign nxt_addr  = nxt_idx.word[`MEM_DEPTH_LOG2-1:0];
    assign last_beat = (nxt_idx.ln.beat == `BEAT_W'(`BURST_BEATS - 1));

    // Bit-level merge under the store mask
    assign merged = (mem_q[cmd_addr] & ~mem.wmask) | (mem.wdata & mem.wmask);

    // Busy flag and return strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.ddr_ready <= 1'b1;
            mem.rvalid    <= 1'b0;
            bursting      <= 1'b0;
        end else begin
            mem.rvalid <= 1'b0;
            if (start) begin
                mem.ddr_ready <= 1'b0;                           // Busy from next cycle
                mem.rvalid    <= 1'b1;                           // Store ack, read word or beat 0
                bursting      <= mem.burst_mode && !mem.write_enable;
            end else if (bursting) begin
                mem.rvalid <= 1'b1;
                if (last_beat) begin
                    bursting <= 1'b0;                            // Beat 7 goes out now
                end
            end else begin
                mem.ddr_ready <= 1'b1;                           // Idle again
            end
        end
    end

    // Array access and read data
    always_ff @(posedge clk) begin
        if (start) begin
            cur_idx <= mem.ddr_index;
            if (mem.write_enable) begin
                mem_q[cmd_addr] <= merged;
            end else begin
                mem.rdata <= mem_q[cmd_addr];                    // Single word or beat 0
            end
        end else if (bursting) begin
            cur_idx   <= nxt_idx;
            mem.rdata <= mem_q[nxt_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/channel_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module channel_arb import mem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,

    // Request side of the three channels
    input  logic [`MEM_ADDR_W-1:0]  sw_index,         // Store word index
    input  logic [`MEM_ADDR_W-1:0]  lw_index,         // Load word index
    input  logic [`MEM_ADDR_W-1:0]  pc_index,         // Fetch index, beat bits ignored
    input  logic                    sw_index_valid,
    input  logic                    lw_index_valid,
    input  logic                    pc_index_valid,
    input  logic [`MEM_DATA_W-1:0]  sw2arb_write_mask, // 1 = write this bit
    input  logic [`MEM_DATA_W-1:0]  sw2ddr_write_data,

    // Assembled line from the collector
    input  logic [`LINE_W-1:0]      line,
    input  logic                    line_valid,        // One-cycle, line complete

    ddr_if.ctrl                     ddr,

    // Response side
    output logic                    sw_index_ready,
    output logic                    lw_index_ready,
    output logic                    pc_index_ready,
    output logic [`MEM_DATA_W-1:0]  arb2lw_read_data,
    output logic [`LINE_W-1:0]      arb2pc_fetch_burst_read_inst
);

    // Grant bits: 0 sw, 1 lw, 2 pc; all zero means idle
    logic [2:0]  grant;
    logic        busy;
    logic        done;        // Last cycle of the current transaction
    logic [2:0]  req;         // Valids still waiting for service
    logic [2:0]  pick;        // One-hot winner
    logic        issue;       // Register a new grant this edge
    mem_index_u  cmd_idx;     // Index of the winner

    assign busy = |grant;

    // Store and load end on rvalid, fetch on the assembled line
    assign done = ((grant[0] || grant[1]) && ddr.rvalid) || (grant[2] && line_valid);

    // The channel finishing now still shows valid at this edge, keep it out
    assign req = {pc_index_valid, lw_index_valid, sw_index_valid} & ~grant;

    // Fixed priority, sw over lw over pc
    assign pick[0] = req[0];
    assign pick[1] = req[1] && !req[0];
    assign pick[2] = req[2] && !req[1] && !req[0];

    assign issue = (!busy || done) && ddr.ddr_ready && (|pick);

    always_comb begin
        cmd_idx.word = pc_index;             // Fetch by default
        if (pick[0]) begin
            cmd_idx.word = sw_index;
        end else if (pick[1]) begin
            cmd_idx.word = lw_index;
        end else begin
            cmd_idx.ln.beat = '0;            // Lines always start at beat 0
        end
    end

    // Grant and command strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant            <= 3'b000;
            ddr.chip_enable  <= 1'b0;
            ddr.write_enable <= 1'b0;
            ddr.burst_mode   <= 1'b0;
        end else begin
            ddr.chip_enable <= 1'b0;         // Strobe lasts one cycle
            if (done) begin
                grant <= 3'b000;             // Back to idle
            end
            if (issue) begin
                grant            <= pick;
                ddr.chip_enable  <= 1'b1;
                ddr.write_enable <= pick[0]; // Only the store channel writes
                ddr.burst_mode   <= pick[2]; // Only fetch reads a line
            end
        end
    end

    // Command payload, captured with the grant
    always_ff @(posedge clk) begin
        if (issue) begin
            ddr.ddr_index <= cmd_idx;
            ddr.wdata     <= sw2ddr_write_data;
            ddr.wmask     <= sw2arb_write_mask;
        end
    end

    // Readies pulse in the completion cycle of the granted channel only
    assign sw_index_ready = grant[0] && ddr.rvalid;
    assign lw_index_ready = grant[1] && ddr.rvalid;
    assign pc_index_ready = grant[2] && line_valid;

    // Responses reach only their own channel, zero elsewhere
    assign arb2lw_read_data             = lw_index_ready ? ddr.rdata : '0;
    assign arb2pc_fetch_burst_read_inst = pc_index_ready ? line : '0;

endmodule

`default_nettype wire

// File: hw/ddr_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

interface ddr_if import mem_pkg::*; ();

    // Command from the arbiter
    mem_index_u              ddr_index;      // Word or line index
    logic                    chip_enable;    // One-cycle command strobe
    logic                    write_enable;   // 1 store, 0 read
    logic                    burst_mode;     // Eight-beat line read
    logic [`MEM_DATA_W-1:0]  wdata;          // Store data
    logic [`MEM_DATA_W-1:0]  wmask;          // Per-bit write enables

    // Return path from the memory
    logic [`MEM_DATA_W-1:0]  rdata;          // Read word or burst beat
    logic                    rvalid;         // Completion / beat strobe
    logic                    ddr_ready;      // Low while an operation runs

    // Arbiter side
    modport ctrl (
        output ddr_index, chip_enable, write_enable, burst_mode, wdata, wmask,
        input  rdata, rvalid, ddr_ready
    );

    // Memory side
    modport mem (
        input  ddr_index, chip_enable, write_enable, burst_mode, wdata, wmask,
        output rdata, rvalid, ddr_ready
    );

    // Passive observer, used by the line collector
    modport mon (
        input  ddr_index, chip_enable, write_enable, burst_mode, wdata, wmask,
        input  rdata, rvalid, ddr_ready
    );

endinterface

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

    // One index word, two readings of the same bits
    // Store and load use the flat word address
    // Fetch and the burst engine split it into line and beat
    typedef union packed {
        logic [`MEM_ADDR_W-1:0] word;                // Flat word address
        struct packed {
            logic [`MEM_ADDR_W-`BEAT_W-1:0] line;    // Line number, upper bits
            logic [`BEAT_W-1:0]             beat;    // Word inside the line
        } ln;
    } mem_index_u;

endpackage

`default_nettype wire

// File: hw/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Index and word sizes seen on every channel
`define MEM_ADDR_W      19    // Word index width
`define MEM_DATA_W      64    // One data word

// Fetch line geometry
`define BURST_BEATS     8     // Words per instruction line
`define BEAT_W          3     // Beat field inside the index
`define LINE_W          512   // BURST_BEATS * MEM_DATA_W

// Behavioral array size
`define MEM_DEPTH_LOG2  10    // Only the low index bits address storage

`endif
